//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_taitosj_video_mix
FLAGS     ?= --binary --timing --assert -Wno-fatal
OBJ_DIR   ?= obj_dir
PASS_MSG  := Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f src.f

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- hdl/layer_priority_mixer.sv
module layer_priority_mixer (
	input  logic                          syncbus_PH,
	input  logic                          EXROM2,
	input  taitosj_bus_pkg::cpu_addr_t    cpu_addr_i,
	input  taitosj_bus_pkg::cpu_data_t    cpu_data_i,
	input  logic                          cpu_wr_i,
	tile_pix_if.dst                       pix,
	input  taitosj_video_pkg::pix_t       obj_pix_i,
	input  taitosj_video_pkg::obj_code_t  obj_code_i,
	input  logic                          blank_i,
	output taitosj_video_pkg::rgb3_t      red_o,
	output taitosj_video_pkg::rgb3_t      green_o,
	output taitosj_video_pkg::rgb3_t      blue_o
);

	logic [1:0]                       pry_q;
	logic                             pal_bit8_q;
	taitosj_bus_pkg::cpu_addr_t       pal_ofs;
	logic                             pal_wr;
	taitosj_video_pkg::pal_entry_t    pal_ram [2**$bits(taitosj_video_pkg::pal_idx_t)];
	taitosj_video_pkg::pix_t          ord_pix  [taitosj_video_pkg::N_TILE_LAYERS];
	taitosj_video_pkg::tile_code_t    ord_code [taitosj_video_pkg::N_TILE_LAYERS];
	logic                             tile_hit;
	taitosj_video_pkg::pal_idx_t      tile_idx;
	taitosj_video_pkg::pal_idx_t      front_idx;
	taitosj_video_pkg::pal_idx_t      idx_q;
	logic                             blank_d1_q;
	taitosj_video_pkg::pal_entry_t    pal_rd;

	// ==================================================
	// CPU side: priority and palette
	// ==================================================
	// Below-base addresses wrap to large offsets and miss
	assign pal_ofs = cpu_addr_i - taitosj_bus_pkg::PAL_BASE;
	assign pal_wr  = cpu_wr_i && (pal_ofs < taitosj_bus_pkg::PAL_SPAN);

	always_ff @(posedge syncbus_PH or negedge EXROM2) begin
		if (!EXROM2) begin
			pry_q      <= '0;
			pal_bit8_q <= 1'b0;
		end else begin
			if (cpu_wr_i && cpu_addr_i == taitosj_bus_pkg::REG_PRY) begin
				pry_q <= cpu_data_i[1:0];
			end
			if (pal_wr && pal_ofs[0]) begin
				pal_bit8_q <= cpu_data_i[0]; // Ninth bit waits for the even write
			end
		end
	end

	always_ff @(posedge syncbus_PH) begin
		if (pal_wr && !pal_ofs[0]) begin
			pal_ram[pal_ofs[taitosj_bus_pkg::PAL_OFS_W-1:1]] <= {pal_bit8_q, cpu_data_i};
		end
	end

	// ==================================================
	// Front pixel choice
	// ==================================================
	always_comb begin
		if (pry_q[1]) begin // Layer 3 in front
			ord_pix  = '{pix.pix3, pix.pix2, pix.pix1};
			ord_code = '{pix.code3, pix.code2, pix.code1};
		end else begin
			ord_pix  = '{pix.pix1, pix.pix2, pix.pix3};
			ord_code = '{pix.code1, pix.code2, pix.code3};
		end
	end

	// Walk back to front so the frontmost opaque layer wins
	always_comb begin
		tile_hit = 1'b0;
		tile_idx = '0;
		for (int k = taitosj_video_pkg::N_TILE_LAYERS - 1; k >= 0; k--) begin
			if (ord_pix[k] != '0) begin
				tile_hit = 1'b1;
				tile_idx = {ord_code[k], ord_pix[k]};
			end
		end
	end

	always_comb begin
		if (obj_pix_i != '0 && (pry_q[0] || !tile_hit)) begin
			front_idx = {obj_code_i, 1'b0, obj_pix_i};
		end else begin
			front_idx = tile_idx; // Zero when nothing is opaque
		end
	end

	// ==================================================
	// Two-stage output pipeline
	// ==================================================
	assign pal_rd = pal_ram[idx_q];

	always_ff @(posedge syncbus_PH or negedge EXROM2) begin
		if (!EXROM2) begin
			idx_q      <= '0;
			blank_d1_q <= 1'b0;
			red_o      <= '0;
			green_o    <= '0;
			blue_o     <= '0;
		end else begin
			idx_q      <= front_idx;
			blank_d1_q <= blank_i;
			if (blank_d1_q) begin
				red_o   <= '0;
				green_o <= '0;
				blue_o  <= '0;
			end else begin
				red_o   <= ~pal_rd[8:6]; // Board drives inverted colour
				green_o <= ~pal_rd[5:3];
				blue_o  <= ~pal_rd[2:0];
			end
		end
	end

endmodule

//--- hdl/plane_shifter.sv
module plane_shifter #(
	parameter type ROW_T = taitosj_video_pkg::tile_row_t
) (
	input  logic                    syncbus_PH,
	input  logic                    EXROM2,
	input  logic                    load_i,
	input  logic                    clear_i,
	input  ROW_T                    row_i,
	output taitosj_video_pkg::pix_t pix_o
);

	logic [$bits(ROW_T)-1:0]      row_bits;
	taitosj_video_pkg::plane_row_t row_planes;
	logic                          row_flip;
	taitosj_video_pkg::plane_row_t sh_q;

	// Planes sit in the top bits; a wider payload carries a flag in bit 0
	assign row_bits   = row_i;
	assign row_planes = row_bits[$bits(ROW_T)-1 -: taitosj_video_pkg::PLANE_ROW_W];
	assign row_flip   = ($bits(ROW_T) > taitosj_video_pkg::PLANE_ROW_W) ? row_bits[0] : 1'b0;

	always_ff @(posedge syncbus_PH or negedge EXROM2) begin
		if (!EXROM2) begin
			sh_q <= '0;
		end else if (clear_i) begin
			sh_q <= '0; // Layer switched off
		end else if (load_i) begin
			sh_q <= taitosj_video_pkg::rev_planes(row_planes, row_flip);
		end else begin
			sh_q.r <= {sh_q.r[taitosj_video_pkg::ROW_W-2:0], 1'b0};
			sh_q.g <= {sh_q.g[taitosj_video_pkg::ROW_W-2:0], 1'b0};
			sh_q.b <= {sh_q.b[taitosj_video_pkg::ROW_W-2:0], 1'b0};
		end
	end

	// MSB of each plane forms the current pixel
	assign pix_o = {
		sh_q.b[taitosj_video_pkg::ROW_W-1],
		sh_q.g[taitosj_video_pkg::ROW_W-1],
		sh_q.r[taitosj_video_pkg::ROW_W-1]
	};

endmodule

//--- hdl/sprite_plane.sv
module sprite_plane (
	input  logic                          syncbus_PH,
	input  logic                          EXROM2,
	input  taitosj_bus_pkg::cpu_addr_t    cpu_addr_i,
	input  taitosj_bus_pkg::cpu_data_t    cpu_data_i,
	input  logic                          cpu_wr_i,
	input  taitosj_video_pkg::obj_row_t   obj_row_i,
	input  logic                          obj_load_i,
	output taitosj_video_pkg::pix_t       obj_pix_o,
	output taitosj_video_pkg::obj_code_t  obj_code_o
);

	taitosj_video_pkg::obj_code_t obj_code_q;

	// ==================================================
	// Sprite colour code
	// ==================================================
	// Shares SMD3 with tile layer 3, upper field only
	always_ff @(posedge syncbus_PH or negedge EXROM2) begin
		if (!EXROM2) begin
			obj_code_q <= '0;
		end else if (cpu_wr_i && cpu_addr_i == taitosj_bus_pkg::REG_SMD3) begin
			obj_code_q <= cpu_data_i[5:4];
		end
	end

	assign obj_code_o = obj_code_q;

	// ==================================================
	// Sprite shifter
	// ==================================================
	// Row flag selects pixel order per sprite
	plane_shifter #(
		.ROW_T(taitosj_video_pkg::obj_row_t)
	) i_plane_shifter (
		.syncbus_PH (syncbus_PH),
		.EXROM2     (EXROM2),
		.load_i     (obj_load_i),
		.clear_i    (1'b0),       // Sprite plane always on
		.row_i      (obj_row_i),
		.pix_o      (obj_pix_o)
	);

endmodule

//--- hdl/taitosj_bus_pkg.sv
package taitosj_bus_pkg;

	// ==================================================
	// CPU bus widths
	// ==================================================
	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	typedef logic [ADDR_W-1:0] cpu_addr_t;
	typedef logic [DATA_W-1:0] cpu_data_t;

	// ==================================================
	// Video register write map
	// ==================================================
	localparam cpu_addr_t REG_SMD12 = 16'hD506; // Tile layer 1 and 2 colour codes
	localparam cpu_addr_t REG_SMD3  = 16'hD507; // Tile layer 3 and sprite codes
	localparam cpu_addr_t REG_SOFF  = 16'hD600; // Layer enables, tile flip
	localparam cpu_addr_t REG_PRY   = 16'hD300; // Priority control

	// Palette RAM window, two bytes per entry
	localparam cpu_addr_t PAL_BASE  = 16'hD200;
	localparam int        PAL_SPAN  = 128;
	localparam int        PAL_OFS_W = $clog2(PAL_SPAN); // Byte offset inside window

endpackage

//--- hdl/taitosj_video_mix.sv
module taitosj_video_mix (
	input  logic                                           syncbus_PH,
	input  logic                                           EXROM2,
	input  taitosj_bus_pkg::cpu_addr_t                     cpu_addr_i,
	input  taitosj_bus_pkg::cpu_data_t                     cpu_data_i,
	input  logic                                           cpu_wr_i,
	input  taitosj_video_pkg::tile_row_t                   tile_row_i,
	input  logic [taitosj_video_pkg::N_TILE_LAYERS-1:0]    tile_load_i,
	input  taitosj_video_pkg::obj_row_t                    obj_row_i,
	input  logic                                           obj_load_i,
	input  logic                                           blank_i,
	output taitosj_video_pkg::rgb3_t                       red_o,
	output taitosj_video_pkg::rgb3_t                       green_o,
	output taitosj_video_pkg::rgb3_t                       blue_o
);

	taitosj_video_pkg::pix_t      obj_pix;
	taitosj_video_pkg::obj_code_t obj_code;

	tile_pix_if tile_pix ();

	// ==================================================
	// Pixel sources
	// ==================================================
	tile_layer_bank i_tile_layer_bank (
		.syncbus_PH  (syncbus_PH),
		.EXROM2      (EXROM2),
		.cpu_addr_i  (cpu_addr_i),
		.cpu_data_i  (cpu_data_i),
		.cpu_wr_i    (cpu_wr_i),
		.tile_row_i  (tile_row_i),
		.tile_load_i (tile_load_i),
		.pix         (tile_pix.src)
	);

	sprite_plane i_sprite_plane (
		.syncbus_PH (syncbus_PH),
		.EXROM2     (EXROM2),
		.cpu_addr_i (cpu_addr_i),
		.cpu_data_i (cpu_data_i),
		.cpu_wr_i   (cpu_wr_i),
		.obj_row_i  (obj_row_i),
		.obj_load_i (obj_load_i),
		.obj_pix_o  (obj_pix),
		.obj_code_o (obj_code)
	);

	// Priority, palette and RGB
	layer_priority_mixer i_layer_priority_mixer (
		.syncbus_PH (syncbus_PH),
		.EXROM2     (EXROM2),
		.cpu_addr_i (cpu_addr_i),
		.cpu_data_i (cpu_data_i),
		.cpu_wr_i   (cpu_wr_i),
		.pix        (tile_pix.dst),
		.obj_pix_i  (obj_pix),
		.obj_code_i (obj_code),
		.blank_i    (blank_i),
		.red_o      (red_o),
		.green_o    (green_o),
		.blue_o     (blue_o)
	);

endmodule

//--- hdl/taitosj_video_pkg.sv
package taitosj_video_pkg;

	// ==================================================
	// Layer geometry
	// ==================================================
	localparam int ROW_W         = 8; // Pixels per plane row
	localparam int N_TILE_LAYERS = 3;
	localparam int PLANE_ROW_W   = 3 * ROW_W;

	typedef logic [2:0] pix_t;       // Zero is transparent
	typedef logic [2:0] tile_code_t;
	typedef logic [1:0] obj_code_t;

	// Bit-plane row as read from graphics RAM
	typedef struct packed {
		logic [ROW_W-1:0] r;
		logic [ROW_W-1:0] g;
		logic [ROW_W-1:0] b;
	} plane_row_t;

	typedef plane_row_t tile_row_t;

	// Sprite row carries its own horizontal inversion
	typedef struct packed {
		plane_row_t planes;
		logic       inv;
	} obj_row_t;

	typedef logic [5:0] pal_idx_t;
	typedef logic [8:0] pal_entry_t; // {R,G,B} 3 bits each
	typedef logic [2:0] rgb3_t;

	// Mirror each plane so the LSB is shifted out first
	function automatic plane_row_t rev_planes(plane_row_t row, logic flip);
		plane_row_t res;
		res = row;
		if (flip) begin
			for (int i = 0; i < ROW_W; i++) begin
				res.r[i] = row.r[ROW_W-1-i];
				res.g[i] = row.g[ROW_W-1-i];
				res.b[i] = row.b[ROW_W-1-i];
			end
		end
		return res;
	endfunction

endpackage

//--- hdl/tile_layer_bank.sv
module tile_layer_bank (
	input  logic                                           syncbus_PH,
	input  logic                                           EXROM2,
	input  taitosj_bus_pkg::cpu_addr_t                     cpu_addr_i,
	input  taitosj_bus_pkg::cpu_data_t                     cpu_data_i,
	input  logic                                           cpu_wr_i,
	input  taitosj_video_pkg::tile_row_t                   tile_row_i,
	input  logic [taitosj_video_pkg::N_TILE_LAYERS-1:0]    tile_load_i,
	tile_pix_if.src                                        pix
);

	taitosj_video_pkg::tile_code_t                 code1_q;
	taitosj_video_pkg::tile_code_t                 code2_q;
	taitosj_video_pkg::tile_code_t                 code3_q;
	logic [taitosj_video_pkg::N_TILE_LAYERS-1:0]   layer_en_q;
	logic                                          flip_q;
	taitosj_video_pkg::tile_row_t                  row_f;
	logic [taitosj_video_pkg::N_TILE_LAYERS-1:0]   load_g;
	taitosj_video_pkg::pix_t                       layer_pix [taitosj_video_pkg::N_TILE_LAYERS];

	// ==================================================
	// CPU registers
	// ==================================================
	always_ff @(posedge syncbus_PH or negedge EXROM2) begin
		if (!EXROM2) begin
			code1_q    <= '0;
			code2_q    <= '0;
			code3_q    <= '0;
			layer_en_q <= '0;
			flip_q     <= 1'b0;
		end else if (cpu_wr_i) begin
			if (cpu_addr_i == taitosj_bus_pkg::REG_SMD12) begin
				code1_q <= cpu_data_i[2:0];
				code2_q <= cpu_data_i[6:4]; // Bank bits are not kept
			end
			if (cpu_addr_i == taitosj_bus_pkg::REG_SMD3) begin
				code3_q <= cpu_data_i[2:0];
			end
			if (cpu_addr_i == taitosj_bus_pkg::REG_SOFF) begin
				layer_en_q <= cpu_data_i[2:0];
				flip_q     <= cpu_data_i[3];
			end
		end
	end

	// ==================================================
	// Layer shifters
	// ==================================================
	// Flip is applied once here, shared by all three layers
	assign row_f  = taitosj_video_pkg::rev_planes(tile_row_i, flip_q);
	assign load_g = tile_load_i & layer_en_q;

	for (genvar k = 0; k < taitosj_video_pkg::N_TILE_LAYERS; k++) begin : g_layer
		plane_shifter #(
			.ROW_T(taitosj_video_pkg::tile_row_t)
		) i_plane_shifter (
			.syncbus_PH (syncbus_PH),
			.EXROM2     (EXROM2),
			.load_i     (load_g[k]),
			.clear_i    (~layer_en_q[k]), // Held empty while disabled
			.row_i      (row_f),
			.pix_o      (layer_pix[k])
		);
	end

	assign pix.pix1  = layer_pix[0];
	assign pix.pix2  = layer_pix[1];
	assign pix.pix3  = layer_pix[2];
	assign pix.code1 = code1_q;
	assign pix.code2 = code2_q;
	assign pix.code3 = code3_q;

endmodule

//--- hdl/tile_pix_if.sv
interface tile_pix_if;

	taitosj_video_pkg::pix_t       pix1;
	taitosj_video_pkg::pix_t       pix2;
	taitosj_video_pkg::pix_t       pix3;
	taitosj_video_pkg::tile_code_t code1;
	taitosj_video_pkg::tile_code_t code2;
	taitosj_video_pkg::tile_code_t code3;

	modport src (
		output pix1, pix2, pix3,
		output code1, code2, code3
	);

	modport dst (
		input pix1, pix2, pix3,
		input code1, code2, code3
	);

endinterface

//--- sim/tb_clock_gen.sv
module tb_clock_gen #(
	parameter int PERIOD       = 4,
	parameter int RESET_CYCLES = 10
) (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD / 2) clk_o = ~clk_o;
	end

	// Release on a falling edge, clear of the sampling edge
	initial begin
		rst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		rst_n_o = 1'b1;
	end

endmodule

//--- sim/tb_taitosj_video_mix.sv
module tb_taitosj_video_mix;

	localparam int ROW_W      = taitosj_video_pkg::ROW_W;
	localparam int NL         = taitosj_video_pkg::N_TILE_LAYERS;
	localparam int N_PAL      = taitosj_bus_pkg::PAL_SPAN / 2;
	localparam int LEN_INIT   = 150; // Reset, idle, palette fill
	localparam int LEN_TESTS  = 130; // Order, flip, enable, priority, blank
	localparam int MAX_CYCLES = 2 * (LEN_INIT + LEN_TESTS);

	logic                          syncbus_PH;
	logic                          EXROM2;
	taitosj_bus_pkg::cpu_addr_t    cpu_addr_i;
	taitosj_bus_pkg::cpu_data_t    cpu_data_i;
	logic                          cpu_wr_i;
	taitosj_video_pkg::tile_row_t  tile_row_i;
	logic [NL-1:0]                 tile_load_i;
	taitosj_video_pkg::obj_row_t   obj_row_i;
	logic                          obj_load_i;
	logic                          blank_i;
	taitosj_video_pkg::rgb3_t      red_o;
	taitosj_video_pkg::rgb3_t      green_o;
	taitosj_video_pkg::rgb3_t      blue_o;

	// ==================================================
	// Reference model state
	// ==================================================
	taitosj_video_pkg::pix_t       m_tile [NL][ROW_W]; // Pixels in output order
	int                            m_tpos [NL];        // ROW_W means empty
	taitosj_video_pkg::pix_t       m_obj [ROW_W];
	int                            m_opos;
	taitosj_video_pkg::tile_code_t m_code [NL];
	taitosj_video_pkg::obj_code_t  m_ocode;
	logic [NL-1:0]                 m_en;
	logic                          m_flip;
	logic [1:0]                    m_pry;
	logic                          m_bit8;
	taitosj_video_pkg::pal_entry_t m_pal [N_PAL];
	bit                            m_pal_ok [N_PAL];  // Entry written since start
	taitosj_video_pkg::pal_idx_t   m_idx;             // First delay stage
	logic                          m_blank;
	logic [8:0]                    exp_rgb;           // Second delay stage
	logic                          exp_ok = 1'b0;
	int                            seed   = 15;
	int                            err_r  = 0;
	int                            err_g  = 0;
	int                            err_b  = 0;
	int                            n_chk  = 0;
	int                            n_lit  = 0;

	tb_clock_gen #(.PERIOD(4), .RESET_CYCLES(10)) i_tb_clock_gen (
		.clk_o   (syncbus_PH),
		.rst_n_o (EXROM2)
	);

	taitosj_video_mix i_taitosj_video_mix (
		.syncbus_PH  (syncbus_PH),
		.EXROM2      (EXROM2),
		.cpu_addr_i  (cpu_addr_i),
		.cpu_data_i  (cpu_data_i),
		.cpu_wr_i    (cpu_wr_i),
		.tile_row_i  (tile_row_i),
		.tile_load_i (tile_load_i),
		.obj_row_i   (obj_row_i),
		.obj_load_i  (obj_load_i),
		.blank_i     (blank_i),
		.red_o       (red_o),
		.green_o     (green_o),
		.blue_o      (blue_o)
	);

	function automatic taitosj_video_pkg::pix_t row_pixel(
		input taitosj_video_pkg::plane_row_t row,
		input int                            slot,
		input logic                          flip
	);
		int src;
		src = flip ? slot : ROW_W - 1 - slot; // Straight rows leave MSB first
		return {row.b[src], row.g[src], row.r[src]};
	endfunction

	function automatic taitosj_video_pkg::plane_row_t random_row(input logic opaque);
		logic [31:0]                   rnd;
		taitosj_video_pkg::plane_row_t row;
		rnd = $random(seed);
		row = rnd[taitosj_video_pkg::PLANE_ROW_W-1:0];
		if (opaque) row.r = '1; // Every pixel non-zero
		return row;
	endfunction

	// Frontmost opaque tile wins unless PRY bit 0 puts the sprite ahead
	function automatic taitosj_video_pkg::pal_idx_t front_index();
		taitosj_video_pkg::pal_idx_t idx;
		taitosj_video_pkg::pix_t     tp;
		taitosj_video_pkg::pix_t     op;
		logic                        found;
		int                          lay;
		idx   = '0;
		found = 1'b0;
		for (int n = 0; n < NL; n++) begin
			lay = m_pry[1] ? NL - 1 - n : n;
			tp  = (m_tpos[lay] < ROW_W) ? m_tile[lay][m_tpos[lay]] : '0;
			if (!found && tp != '0) begin
				found = 1'b1;
				idx   = {m_code[lay], tp};
			end
		end
		op = (m_opos < ROW_W) ? m_obj[m_opos] : '0;
		if (op != '0 && (m_pry[0] || !found)) idx = {m_ocode, 1'b0, op};
		return idx;
	endfunction

	task automatic reset_model();
		for (int l = 0; l < NL; l++) begin
			m_tpos[l] = ROW_W;
			m_code[l] = '0;
		end
		m_opos  = ROW_W;
		m_ocode = '0;
		m_en    = '0;
		m_flip  = 1'b0;
		m_pry   = '0;
		m_bit8  = 1'b0;
		m_idx   = '0;
		m_blank = 1'b0;
		exp_rgb = '0;
		exp_ok  = 1'b1;
	endtask

	// ==================================================
	// Model update and output checks
	// ==================================================
	always @(posedge syncbus_PH) begin : ref_model
		taitosj_bus_pkg::cpu_addr_t ofs;
		logic [8:0]                 nxt_rgb;
		logic                       nxt_ok;
		if (exp_ok) begin
			assert (red_o === exp_rgb[8:6]) else begin
				$display("[ERROR] red_o: got %h, expected %h", red_o, exp_rgb[8:6]);
				err_r++;
			end
			assert (green_o === exp_rgb[5:3]) else begin
				$display("[ERROR] green_o: got %h, expected %h", green_o, exp_rgb[5:3]);
				err_g++;
			end
			assert (blue_o === exp_rgb[2:0]) else begin
				$display("[ERROR] blue_o: got %h, expected %h", blue_o, exp_rgb[2:0]);
				err_b++;
			end
			n_chk++;
			if (exp_rgb != '0) n_lit++;
		end
		if (!EXROM2) begin
			reset_model();
		end else begin
			nxt_ok  = m_blank || m_pal_ok[m_idx]; // Unwritten entry is unknown
			nxt_rgb = m_blank ? 9'h000 : ~m_pal[m_idx];
			m_idx   = front_index();
			m_blank = blank_i;
			for (int l = 0; l < NL; l++) begin
				if (!m_en[l]) begin
					m_tpos[l] = ROW_W; // Disabled layer stays empty
				end else if (tile_load_i[l]) begin
					for (int s = 0; s < ROW_W; s++) begin
						m_tile[l][s] = row_pixel(tile_row_i, s, m_flip);
					end
					m_tpos[l] = 0;
				end else if (m_tpos[l] < ROW_W) begin
					m_tpos[l]++;
				end
			end
			if (obj_load_i) begin
				for (int s = 0; s < ROW_W; s++) begin
					m_obj[s] = row_pixel(obj_row_i.planes, s, obj_row_i.inv);
				end
				m_opos = 0;
			end else if (m_opos < ROW_W) begin
				m_opos++;
			end
			ofs = cpu_addr_i - taitosj_bus_pkg::PAL_BASE;
			if (cpu_wr_i) begin
				if (cpu_addr_i == taitosj_bus_pkg::REG_SMD12) begin
					m_code[0] = cpu_data_i[2:0];
					m_code[1] = cpu_data_i[6:4];
				end
				if (cpu_addr_i == taitosj_bus_pkg::REG_SMD3) begin
					m_code[2] = cpu_data_i[2:0];
					m_ocode   = cpu_data_i[5:4];
				end
				if (cpu_addr_i == taitosj_bus_pkg::REG_SOFF) begin
					m_en   = cpu_data_i[2:0];
					m_flip = cpu_data_i[3];
				end
				if (cpu_addr_i == taitosj_bus_pkg::REG_PRY) m_pry = cpu_data_i[1:0];
				if (int'(ofs) < taitosj_bus_pkg::PAL_SPAN) begin
					if (ofs[0]) begin
						m_bit8 = cpu_data_i[0]; // Ninth bit for the next even write
					end else begin
						m_pal[int'(ofs) / 2]    = {m_bit8, cpu_data_i};
						m_pal_ok[int'(ofs) / 2] = 1'b1;
					end
				end
			end
			exp_rgb = nxt_rgb;
			exp_ok  = nxt_ok;
		end
	end

	// ==================================================
	// Stimulus on the falling edge
	// ==================================================
	task automatic idle(input int n);
		repeat (n) @(negedge syncbus_PH);
	endtask

	task automatic cpu_write(
		input taitosj_bus_pkg::cpu_addr_t addr,
		input taitosj_bus_pkg::cpu_data_t data
	);
		cpu_addr_i = addr;
		cpu_data_i = data;
		cpu_wr_i   = 1'b1;
		@(negedge syncbus_PH);
		cpu_wr_i   = 1'b0;
	endtask

	task automatic load_rows(
		input logic [NL-1:0]                tile_mask,
		input taitosj_video_pkg::tile_row_t trow,
		input logic                         obj_ld,
		input taitosj_video_pkg::obj_row_t  orow
	);
		tile_row_i  = trow;
		tile_load_i = tile_mask;
		obj_row_i   = orow;
		obj_load_i  = obj_ld;
		@(negedge syncbus_PH);
		tile_load_i = '0;
		obj_load_i  = 1'b0;
	endtask

	// Entry 0 is white, so empty rows come out black
	task automatic load_palette();
		logic [31:0]                   rnd;
		taitosj_video_pkg::pal_entry_t word;
		taitosj_bus_pkg::cpu_addr_t    addr;
		for (int i = 0; i < N_PAL; i++) begin
			rnd  = $random(seed);
			word = (i == 0) ? 9'h1FF : rnd[8:0];
			addr = taitosj_bus_pkg::PAL_BASE + taitosj_bus_pkg::cpu_addr_t'(2 * i);
			cpu_write(addr + 16'd1, {rnd[15:9], word[8]}); // Upper bits are ignored
			cpu_write(addr, word[7:0]);
		end
	endtask

	initial begin : stimulus
		taitosj_video_pkg::tile_row_t trow;
		taitosj_video_pkg::obj_row_t  orow;
		cpu_addr_i  = '0;
		cpu_data_i  = '0;
		cpu_wr_i    = 1'b0;
		tile_row_i  = '0;
		tile_load_i = '0;
		obj_row_i   = '0;
		obj_load_i  = 1'b0;
		blank_i     = 1'b0;
		wait (EXROM2 === 1'b1);
		@(negedge syncbus_PH);
		idle(4);
		load_palette();
		idle(6);
		cpu_write(taitosj_bus_pkg::REG_SMD12, 8'h52); // code2 5, code1 2
		cpu_write(taitosj_bus_pkg::REG_SMD3, 8'h37);  // Sprite code 3, code3 7
		cpu_write(taitosj_bus_pkg::REG_SOFF, 8'h07);
		trow = random_row(1'b0);
		load_rows(3'b001, trow, 1'b0, '0);
		idle(10);
		cpu_write(taitosj_bus_pkg::REG_SOFF, 8'h0F); // Same row flipped
		load_rows(3'b001, trow, 1'b0, '0);
		idle(10);
		cpu_write(taitosj_bus_pkg::REG_SOFF, 8'h07);
		orow.planes = random_row(1'b0);
		orow.inv    = 1'b1;
		load_rows(3'b000, trow, 1'b1, orow);
		idle(10);
		load_rows(3'b111, random_row(1'b1), 1'b0, '0);
		idle(2);
		cpu_write(taitosj_bus_pkg::REG_SOFF, 8'h06); // Layer 2 shows through
		idle(1);
		cpu_write(taitosj_bus_pkg::REG_SOFF, 8'h04); // Layer 3 shows for the last pixels
		idle(8);
		cpu_write(taitosj_bus_pkg::REG_SOFF, 8'h07);
		for (int p = 0; p < 4; p++) begin
			cpu_write(taitosj_bus_pkg::REG_PRY, 8'(p));
			load_rows(3'b100, random_row(1'b1), 1'b0, '0);
			load_rows(3'b010, random_row(1'b1), 1'b0, '0);
			orow.planes = random_row(1'b1);
			orow.inv    = p[0];
			load_rows(3'b001, random_row(1'b1), 1'b1, orow);
			idle(10);
		end
		load_rows(3'b111, random_row(1'b1), 1'b1, orow);
		idle(2);
		blank_i = 1'b1;
		idle(3);
		blank_i = 1'b0;
		idle(10);
		$display("Error counts: red_o %0d, green_o %0d, blue_o %0d in %0d checks",
			err_r, err_g, err_b, n_chk);
		if (n_lit == 0) $display("No coloured pixel ever reached the RGB outputs");
		if (err_r + err_g + err_b == 0 && n_lit > 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge syncbus_PH);
			cycles++;
		end
		$display("Timeout: stimulus did not finish within %0d cycles", MAX_CYCLES);
		$display("Verification failed");
		$finish;
	end

endmodule

//--- src.f
hdl/taitosj_bus_pkg.sv
hdl/taitosj_video_pkg.sv
hdl/tile_pix_if.sv
hdl/plane_shifter.sv
hdl/tile_layer_bank.sv
hdl/sprite_plane.sv
hdl/layer_priority_mixer.sv
hdl/taitosj_video_mix.sv
sim/tb_clock_gen.sv
sim/tb_taitosj_video_mix.sv
